/* Bender.yml */
package:
  name: rasterizer

sources:
  # Synthesizable design, packages first
  - include_dirs:
      - hdl
    files:
      - hdl/rasterGeomPkg.sv
      - hdl/rasterStreamPkg.sv
      - hdl/edgeFunctionStepper.sv
      - hdl/edgeWalker.sv
      - hdl/fragmentFormatter.sv
      - hdl/rasterizer.sv

  # Simulation only
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/rasterizerTb.sv

/* hdl/edgeFunctionStepper.sv */
// ==========================================================
// Incremental evaluation of the three triangle edge functions
// Holds the current walk position and the edge values there;
// the edge walker moves both with one command per cycle and
// every command takes effect on the next clock edge
// ==========================================================
`timescale 1ns/10ps

module edgeFunctionStepper
    import rasterGeomPkg::*;
    import rasterStreamPkg::*;
(
    input  logic         clk,
    input  triangleAttrT triangle,
    input  stepCmdT      stepCmd,
    output pixelPosT     position,
    output logic         insideTriangle
);

    // Edge function values at the current position
    edgeValuesT edges;

    // Adds an increment to all three edge values
    function automatic edgeValuesT addEdges(edgeValuesT a, edgeValuesT b);
        edgeValuesT sum;
        sum.w0 = a.w0 + b.w0;
        sum.w1 = a.w1 + b.w1;
        sum.w2 = a.w2 + b.w2;
        return sum;
    endfunction

    // Subtracts an increment from all three edge values
    function automatic edgeValuesT subEdges(edgeValuesT a, edgeValuesT b);
        edgeValuesT diff;
        diff.w0 = a.w0 - b.w0;
        diff.w1 = a.w1 - b.w1;
        diff.w2 = a.w2 - b.w2;
        return diff;
    endfunction

    // Position and edge values move together, one command per clock
    always_ff @(posedge clk)
    begin
        case (stepCmd)
            stepLoad:
            begin
                // Start at the top left corner of the box
                edges      <= triangle.edgeStart;
                position.x <= triangle.bbox.startX;
                position.y <= triangle.bbox.startY;
            end
            stepPixelRight:
            begin
                edges      <= addEdges(edges, triangle.edgeIncX);
                position.x <= position.x + 1'b1;
            end
            stepPixelLeft:
            begin
                edges      <= subEdges(edges, triangle.edgeIncX);
                position.x <= position.x - 1'b1;
            end
            stepLineDown:
            begin
                // Only y changes, x stays where the walk left the row
                edges      <= addEdges(edges, triangle.edgeIncY);
                position.y <= position.y + 1'b1;
            end
            default:
            begin
                // Hold keeps position and edge values
            end
        endcase
    end

    // Inside when no edge value is negative, so only the sign bits matter
    assign insideTriangle = !(edges.w0[`ATTRIBUTE_WIDTH-1] | edges.w1[`ATTRIBUTE_WIDTH-1]
                              | edges.w2[`ATTRIBUTE_WIDTH-1]);

endmodule

/* hdl/edgeWalker.sv */
// ==========================================================
// Control FSM of the scanline rasterizer
// Waits for a start pulse, loads the triangle into the edge
// stepper and then walks the bounding box row by row, turning
// at the triangle edges; each cycle it picks one step command
// and raises fragValid for every covered pixel
// The whole walk freezes while fragReady is low
// ==========================================================
`timescale 1ns/10ps
`include "raster_defs.svh"

module edgeWalker
    import rasterGeomPkg::*;
    import rasterStreamPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         startRendering,
    input  triangleAttrT triangle,
    input  pixelPosT     position,
    input  logic         insideTriangle,
    input  logic         fragReady,
    output stepCmdT      stepCmd,
    output logic         capture,
    output logic         fragValid,
    output logic         rasterizerRunning
);

    // The walk ends when y reaches the box end or the last screen row
    localparam logic [`Y_BIT_WIDTH-1:0] yLimit = `Y_RESOLUTION;

    // Top level sequence, the walk itself lives in walkState
    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlLoad,
        ctrlWalking
    } ctrlStateT;

    ctrlStateT ctrlState;
    walkStateT walkState;
    logic      walkRight;
    logic      tryOtherSide;
    logic      insideBox;
    logic      insideAll;
    logic      rowActive;

    // Only x is checked, rows beyond the box end the walk through rowActive
    assign insideBox = (position.x >= triangle.bbox.startX) && (position.x < triangle.bbox.endX);
    assign insideAll = insideTriangle && insideBox;
    assign rowActive = (position.y < triangle.bbox.endY) && (position.y < yLimit);

    // Step selection for the edge stepper
    always_comb
    begin
        stepCmd = stepHold;
        if (ctrlState == ctrlLoad)
            stepCmd = stepLoad;
        else if ((ctrlState == ctrlWalking) && fragReady)
        begin
            // No step while the direction is checked after a line increment,
            // this keeps x from running past the box on the row change
            if (walkState == wsCheckDir)
                stepCmd = stepHold;
            else if ((walkState == wsWalk) && !insideAll)
                stepCmd = stepLineDown;
            else if (walkRight)
                stepCmd = stepPixelRight;
            else
                stepCmd = stepPixelLeft;
        end
    end

    // The formatter samples the position on every active walk cycle
    assign capture = (ctrlState == ctrlWalking) && fragReady;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrlState         <= ctrlIdle;
            walkState         <= wsInit;
            walkRight         <= 1'b1;
            tryOtherSide      <= 1'b0;
            fragValid         <= 1'b0;
            rasterizerRunning <= 1'b0;
        end
        else
        begin
            case (ctrlState)
                ctrlIdle:
                begin
                    fragValid <= 1'b0;
                    if (startRendering)
                    begin
                        rasterizerRunning <= 1'b1;
                        ctrlState         <= ctrlLoad;
                    end
                end
                ctrlLoad:
                begin
                    // The stepper loads the start corner in this same cycle
                    walkState    <= wsInit;
                    walkRight    <= 1'b1;
                    tryOtherSide <= 1'b0;
                    fragValid    <= 1'b0;
                    ctrlState    <= ctrlWalking;
                end
                ctrlWalking:
                begin
                    if (fragReady)
                    begin
                        // Valid only where a state below marks the pixel as covered
                        fragValid <= 1'b0;
                        if (!rowActive)
                        begin
                            // Below the box or the screen, nothing more can be hit
                            rasterizerRunning <= 1'b0;
                            ctrlState         <= ctrlIdle;
                        end
                        else
                        begin
                            case (walkState)
                                wsInit:
                                begin
                                    // The start corner may already be covered
                                    if (insideAll)
                                    begin
                                        fragValid <= 1'b1;
                                        walkState <= wsWalk;
                                    end
                                    else
                                        walkState <= wsSearchEdge;
                                end
                                wsCheckDir:
                                begin
                                    // Inside after the line step means we must first walk out
                                    // in the old direction, otherwise the triangle is assumed
                                    // to lie behind us
                                    if (insideTriangle)
                                        walkState <= wsWalkOut;
                                    else
                                    begin
                                        walkRight <= !walkRight;
                                        walkState <= wsSearchEdge;
                                    end
                                end
                                wsSearchEdge:
                                begin
                                    if (insideAll)
                                    begin
                                        tryOtherSide <= 1'b0;
                                        fragValid    <= 1'b1;
                                        walkState    <= wsWalk;
                                    end
                                    else if (position.x == triangle.bbox.endX)
                                    begin
                                        // Right box edge reached without a hit
                                        // A second failed pass means the row is empty,
                                        // wsWalk then triggers the line step
                                        if (walkRight && tryOtherSide)
                                        begin
                                            tryOtherSide <= 1'b0;
                                            walkState    <= wsWalk;
                                        end
                                        else
                                        begin
                                            tryOtherSide <= 1'b1;
                                            walkRight    <= 1'b0;
                                        end
                                    end
                                    else if (position.x == triangle.bbox.startX)
                                    begin
                                        // Same retry rule mirrored for the left box edge
                                        if (!walkRight && tryOtherSide)
                                        begin
                                            tryOtherSide <= 1'b0;
                                            walkState    <= wsWalk;
                                        end
                                        else
                                        begin
                                            tryOtherSide <= 1'b1;
                                            walkRight    <= 1'b1;
                                        end
                                    end
                                end
                                wsWalkOut:
                                begin
                                    // Leave the triangle or the box, then turn and search
                                    if (!insideTriangle
                                        || (position.x == triangle.bbox.startX)
                                        || (position.x >= triangle.bbox.endX))
                                    begin
                                        walkRight <= !walkRight;
                                        walkState <= wsSearchEdge;
                                    end
                                end
                                wsWalk:
                                begin
                                    // Emit covered pixels until the far edge is crossed
                                    if (insideAll)
                                        fragValid <= 1'b1;
                                    else
                                        walkState <= wsCheckDir;
                                end
                                default:
                                    walkState <= wsInit;
                            endcase
                        end
                    end
                end
                default:
                    ctrlState <= ctrlIdle;
            endcase
        end
    end

endmodule

/* hdl/fragmentFormatter.sv */
// ==========================================================
// Fragment formatting for the output stream
// On each capture the current walk position is turned into a
// framebuffer index, a screen position and a box-relative
// position; the result is registered so it lines up with
// fragValid one cycle later
// ==========================================================
`timescale 1ns/10ps
`include "raster_defs.svh"

module fragmentFormatter
    import rasterGeomPkg::*;
    import rasterStreamPkg::*;
(
    input  logic         clk,
    input  logic         capture,
    input  pixelPosT     position,
    input  triangleAttrT triangle,
    output fragmentT     fragment
);

    logic [`COORD_FIELD_WIDTH-1:0] posX;
    logic [`COORD_FIELD_WIDTH-1:0] posY;
    logic [`COORD_FIELD_WIDTH-1:0] boxX;
    logic [`COORD_FIELD_WIDTH-1:0] boxY;
    logic [`FB_INDEX_WIDTH-1:0]    fbIndex;

    // Widen the coordinates to the packed field width first
    assign posX = `COORD_FIELD_WIDTH'(position.x);
    assign posY = `COORD_FIELD_WIDTH'(position.y);
    assign boxX = `COORD_FIELD_WIDTH'(triangle.bbox.startX);
    assign boxY = `COORD_FIELD_WIDTH'(triangle.bbox.startY);

    // The framebuffer is stored bottom row first, so y is flipped
    assign fbIndex = `FB_INDEX_WIDTH'(((`Y_RESOLUTION - 1) - posY) * `X_RESOLUTION + posX);

    // Fields of the pixel that was current on the capture cycle
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            fragment.fbIndex <= `ATTRIBUTE_WIDTH'(fbIndex);
            // offsetY places this triangle's rows in the full screen
            fragment.screenY <= posY + triangle.offsetY;
            fragment.screenX <= posX;
            fragment.relY    <= posY - boxY;
            fragment.relX    <= posX - boxX;
        end
    end

endmodule

/* hdl/rasterGeomPkg.sv */
// ==========================================================
// Geometry types of the rasterizer
// Screen positions, the triangle bounding box and the full
// triangle description that is sampled on a start pulse
// Modules pull these in by a wildcard import in their header
// ==========================================================
`include "raster_defs.svh"

package rasterGeomPkg;

    // Pixel position inside the screen, x and y are unsigned
    typedef struct packed {
        logic [`X_BIT_WIDTH-1:0] x;
        logic [`Y_BIT_WIDTH-1:0] y;
    } pixelPosT;

    // Bounding box of the triangle
    // The end coordinates are exclusive, so an empty box has start equal to end
    typedef struct packed {
        logic [`X_BIT_WIDTH-1:0] startX;
        logic [`Y_BIT_WIDTH-1:0] startY;
        logic [`X_BIT_WIDTH-1:0] endX;
        logic [`Y_BIT_WIDTH-1:0] endY;
    } boundingBoxT;

    // The three edge functions of a triangle
    // A pixel lies inside when all three are non-negative
    typedef struct packed {
        logic signed [`ATTRIBUTE_WIDTH-1:0] w0;
        logic signed [`ATTRIBUTE_WIDTH-1:0] w1;
        logic signed [`ATTRIBUTE_WIDTH-1:0] w2;
    } edgeValuesT;

    // Complete triangle setup, held stable by the source for the whole render
    typedef struct packed {
        edgeValuesT                    edgeStart;
        edgeValuesT                    edgeIncX;
        edgeValuesT                    edgeIncY;
        boundingBoxT                   bbox;
        logic [`COORD_FIELD_WIDTH-1:0] offsetY;
    } triangleAttrT;

endpackage

/* hdl/rasterStreamPkg.sv */
// ==========================================================
// Control and output types of the rasterizer
// Step commands from the walker to the edge stepper, the walk
// sub-states and the fragment word of the output stream
// ==========================================================
`include "raster_defs.svh"

package rasterStreamPkg;

    // What the edge stepper does on the next clock edge
    typedef enum logic [2:0] {
        stepHold,
        stepLoad,
        stepPixelRight,
        stepPixelLeft,
        stepLineDown
    } stepCmdT;

    // Sub-states of the edge walk inside one triangle
    typedef enum logic [2:0] {
        wsInit,
        wsCheckDir,
        wsSearchEdge,
        wsWalkOut,
        wsWalk
    } walkStateT;

    // One covered pixel, 96 bits
    // fbIndex is zero-extended from the framebuffer index width
    typedef struct packed {
        logic [`ATTRIBUTE_WIDTH-1:0]   fbIndex;
        logic [`COORD_FIELD_WIDTH-1:0] screenY;
        logic [`COORD_FIELD_WIDTH-1:0] screenX;
        logic [`COORD_FIELD_WIDTH-1:0] relY;
        logic [`COORD_FIELD_WIDTH-1:0] relX;
    } fragmentT;

endpackage

/* hdl/raster_defs.svh */
// ==========================================================
// Shared sizing macros for the scanline rasterizer
// Include this file wherever screen size, attribute width or
// coordinate widths are needed; the guard below makes repeated
// inclusion from packages and modules harmless
// ==========================================================
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// Fixed screen size in pixels
`define X_RESOLUTION 128
`define Y_RESOLUTION 128

// One edge-function value or increment, two's complement
`define ATTRIBUTE_WIDTH 32

// Linear framebuffer address width, enough for 128 x 128 pixels
`define FB_INDEX_WIDTH 14

// Every coordinate in a fragment is packed into a field this wide
`define COORD_FIELD_WIDTH 16

// One extra bit so a walk may step one pixel past the screen edge
`define X_BIT_WIDTH ($clog2(`X_RESOLUTION) + 1)
`define Y_BIT_WIDTH ($clog2(`Y_RESOLUTION) + 1)

`endif

/* hdl/rasterizer.sv */
// ==========================================================
// Top level of the scanline rasterizer
// Pulse startRendering with a stable triangle description;
// covered pixels leave as fragments on a valid/ready stream
// until rasterizerRunning falls
// ==========================================================
`timescale 1ns/10ps

module rasterizer
    import rasterGeomPkg::*;
    import rasterStreamPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         startRendering,
    input  triangleAttrT triangle,
    input  logic         fragReady,
    output logic         rasterizerRunning,
    output logic         fragValid,
    output fragmentT     fragment
);

    stepCmdT  stepCmd;
    pixelPosT position;
    logic     insideTriangle;
    logic     capture;

    // Control FSM, owns valid and the running flag
    edgeWalker edgeWalker_inst (
        .clk               (clk),
        .reset             (reset),
        .startRendering    (startRendering),
        .triangle          (triangle),
        .position          (position),
        .insideTriangle    (insideTriangle),
        .fragReady         (fragReady),
        .stepCmd           (stepCmd),
        .capture           (capture),
        .fragValid         (fragValid),
        .rasterizerRunning (rasterizerRunning)
    );

    // Edge values and walk position
    edgeFunctionStepper edgeFunctionStepper_inst (
        .clk            (clk),
        .triangle       (triangle),
        .stepCmd        (stepCmd),
        .position       (position),
        .insideTriangle (insideTriangle)
    );

    // Fragment data, registered on the same edge as fragValid
    fragmentFormatter fragmentFormatter_inst (
        .clk      (clk),
        .capture  (capture),
        .position (position),
        .triangle (triangle),
        .fragment (fragment)
    );

endmodule

/* rasterizer.f */
+incdir+hdl
hdl/rasterGeomPkg.sv
hdl/rasterStreamPkg.sv
hdl/edgeFunctionStepper.sv
hdl/edgeWalker.sv
hdl/fragmentFormatter.sv
hdl/rasterizer.sv
testbench/rasterizerTb.sv

/* testbench/rasterizerTb.sv */
// ==========================================================
// Self-checking testbench for the scanline rasterizer
// Renders random triangles from a fixed seed, with and
// without back-pressure, and compares every fragment with a
// reference model of the covered pixels inside the box
// A cycle watchdog ends the run if the DUT stops responding
// ==========================================================
`timescale 1ns/10ps
`include "raster_defs.svh"

module rasterizerTb
    import rasterGeomPkg::*;
    import rasterStreamPkg::*;
();

    localparam int randomTriCount = 8;
    localparam int stallTriCount  = 6;
    localparam int minArea        = 40;

    logic         clk;
    logic         reset;
    logic         startRendering;
    triangleAttrT triangle;
    logic         fragReady;
    logic         rasterizerRunning;
    logic         fragValid;
    fragmentT     fragment;

    // Reference model state, keys are y * 256 + x
    triangleAttrT triList[$];
    bit           expectedSet[int];
    bit           seenSet[int];
    int           expectedCount;
    int           receivedCount;
    int           errorCount;
    int           testCount;
    int           failedTests;
    int           cycleCount;
    int           cycleLimit = 1000;
    string        currentTest;

    // Stream values from the previous falling edge, for the stall check
    logic         prevReady;
    logic         prevValid;
    fragmentT     prevFragment;
    logic         holdArmed;

    rasterizer rasterizer_inst (
        .clk               (clk),
        .reset             (reset),
        .startRendering    (startRendering),
        .triangle          (triangle),
        .fragReady         (fragReady),
        .rasterizerRunning (rasterizerRunning),
        .fragValid         (fragValid),
        .fragment          (fragment)
    );

    always #10 clk = ~clk;

    // Edge function of the directed edge a to b, positive on its left in screen space
    function automatic int edgeAt(int xa, int ya, int xb, int yb, int x, int y);
        return (x - xa) * (yb - ya) - (y - ya) * (xb - xa);
    endfunction

    function automatic int min3(int a, int b, int c);
        return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
    endfunction

    function automatic int max3(int a, int b, int c);
        return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
    endfunction

    // Vertices must already be ordered so that the inside is non-negative
    function automatic triangleAttrT makeTriangle(int x0, int y0, int x1, int y1, int x2, int y2,
                                                  int bx0, int by0, int bx1, int by1, int offY);
        triangleAttrT t;
        t.edgeStart.w0 = edgeAt(x1, y1, x2, y2, bx0, by0);
        t.edgeStart.w1 = edgeAt(x2, y2, x0, y0, bx0, by0);
        t.edgeStart.w2 = edgeAt(x0, y0, x1, y1, bx0, by0);
        // One pixel right adds dy of the edge, one line down subtracts its dx
        t.edgeIncX.w0  = y2 - y1;
        t.edgeIncX.w1  = y0 - y2;
        t.edgeIncX.w2  = y1 - y0;
        t.edgeIncY.w0  = x1 - x2;
        t.edgeIncY.w1  = x2 - x0;
        t.edgeIncY.w2  = x0 - x1;
        t.bbox.startX  = bx0;
        t.bbox.startY  = by0;
        t.bbox.endX    = bx1;
        t.bbox.endY    = by1;
        t.offsetY      = offY;
        return t;
    endfunction

    function automatic triangleAttrT randomTriangle();
        int x0, y0, x1, y1, x2, y2;
        int area;
        int swapX;
        int swapY;
        area = 0;
        // Thin slivers are rejected and drawn again
        while ((area < minArea) && (area > -minArea))
        begin
            x0   = $urandom_range(0, `X_RESOLUTION - 1);
            y0   = $urandom_range(0, `Y_RESOLUTION - 1);
            x1   = $urandom_range(0, `X_RESOLUTION - 1);
            y1   = $urandom_range(0, `Y_RESOLUTION - 1);
            x2   = $urandom_range(0, `X_RESOLUTION - 1);
            y2   = $urandom_range(0, `Y_RESOLUTION - 1);
            area = edgeAt(x0, y0, x1, y1, x2, y2);
        end
        if (area < 0)
        begin
            swapX = x1;
            swapY = y1;
            x1    = x2;
            y1    = y2;
            x2    = swapX;
            y2    = swapY;
        end
        // End corner of the box is exclusive
        return makeTriangle(x0, y0, x1, y1, x2, y2,
                            min3(x0, x1, x2), min3(y0, y1, y2),
                            max3(x0, x1, x2) + 1, max3(y0, y1, y2) + 1,
                            $urandom_range(0, 1023));
    endfunction

    function automatic int boxArea(triangleAttrT t);
        return (int'(t.bbox.endX) - int'(t.bbox.startX)) * (int'(t.bbox.endY) - int'(t.bbox.startY));
    endfunction

    // Covered set, each edge evaluated directly from its linear form
    task automatic buildModel(triangleAttrT t);
        int w0, w1, w2;
        int dx, dy;
        expectedSet.delete();
        expectedCount = 0;
        for (int y = t.bbox.startY; (y < t.bbox.endY) && (y < `Y_RESOLUTION); y++)
        begin
            for (int x = t.bbox.startX; x < t.bbox.endX; x++)
            begin
                dx = x - t.bbox.startX;
                dy = y - t.bbox.startY;
                w0 = t.edgeStart.w0 + dx * t.edgeIncX.w0 + dy * t.edgeIncY.w0;
                w1 = t.edgeStart.w1 + dx * t.edgeIncX.w1 + dy * t.edgeIncY.w1;
                w2 = t.edgeStart.w2 + dx * t.edgeIncX.w2 + dy * t.edgeIncY.w2;
                if ((w0 >= 0) && (w1 >= 0) && (w2 >= 0))
                begin
                    expectedSet[y * 256 + x] = 1'b1;
                    expectedCount++;
                end
            end
        end
    endtask

    // Fields of a fragment at x, y; the framebuffer is addressed bottom row first
    function automatic fragmentT expectedFragment(int x, int y, triangleAttrT t);
        fragmentT f;
        f.fbIndex = (`Y_RESOLUTION - 1 - y) * `X_RESOLUTION + x;
        f.screenY = y + int'(t.offsetY);
        f.screenX = x;
        f.relY    = y - int'(t.bbox.startY);
        f.relX    = x - int'(t.bbox.startX);
        return f;
    endfunction

    task automatic checkFragment(string name, fragmentT expected, fragmentT actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(string name, int expected, int actual);
        if (actual != expected)
        begin
            errorCount++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic reportProblem(string message);
        errorCount++;
        $display("%s", message);
    endtask

    task automatic closeTest(string name, int errorsBefore);
        testCount++;
        if (errorCount != errorsBefore)
            failedTests++;
        $display("Test %s: %0d of %0d fragments, %s", name, receivedCount, expectedCount,
                 (errorCount == errorsBefore) ? "ok" : "errors found");
    endtask

    // Transfers are sampled half a cycle early, where valid and ready are stable
    always @(negedge clk)
    begin : collectFragments
        int x;
        int y;
        int key;
        if (!reset && holdArmed && !prevReady)
        begin
            checkFlag({currentTest, " fragValid under stall"}, prevValid, fragValid);
            checkFragment({currentTest, " fragment under stall"}, prevFragment, fragment);
        end
        if (!reset && fragValid && fragReady)
        begin
            x   = fragment.screenX;
            y   = int'(fragment.relY) + int'(triangle.bbox.startY);
            key = y * 256 + x;
            if (!expectedSet.exists(key))
                reportProblem($sformatf("%s: fragment at x=%0d y=%0d is not a covered pixel",
                                        currentTest, x, y));
            else if (seenSet.exists(key))
                reportProblem($sformatf("%s: pixel x=%0d y=%0d was sent twice", currentTest, x, y));
            else
                seenSet[key] = 1'b1;
            checkFragment({currentTest, " fragment fields"}, expectedFragment(x, y, triangle),
                          fragment);
            receivedCount++;
        end
        prevReady    = fragReady;
        prevValid    = fragValid;
        prevFragment = fragment;
        holdArmed    = !reset;
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout: the run went past its limit of %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    // One start pulse, then follow the walk until rasterizerRunning falls
    task automatic renderTriangle(string name, triangleAttrT triDesc, bit stall);
        int errorsBefore;
        errorsBefore  = errorCount;
        currentTest   = name;
        buildModel(triDesc);
        seenSet.delete();
        receivedCount = 0;
        @(posedge clk);
        #2;
        triangle       = triDesc;
        startRendering = 1'b1;
        @(posedge clk);
        #2;
        startRendering = 1'b0;
        checkFlag({name, " rasterizerRunning after start"}, 1'b1, rasterizerRunning);
        while (rasterizerRunning === 1'b1)
        begin
            if (stall)
                fragReady = ($urandom_range(0, 1) == 1);
            @(posedge clk);
            #2;
        end
        fragReady = 1'b1;
        checkFlag({name, " fragValid after the end"}, 1'b0, fragValid);
        // With no strays and no repeats, equal counts mean equal sets
        checkCount({name, " fragment count"}, expectedCount, receivedCount);
        closeTest(name, errorsBefore);
    endtask

    initial
    begin
        triangleAttrT emptyTri;
        int           errorsBefore;
        int           factor;
        void'($urandom(63740));
        clk            = 1'b0;
        reset          = 1'b1;
        startRendering = 1'b0;
        triangle       = '0;
        fragReady      = 1'b1;
        holdArmed      = 1'b0;
        errorCount     = 0;
        testCount      = 0;
        failedTests    = 0;
        cycleCount     = 0;

        // Box far away from a small triangle near the top left corner
        emptyTri   = makeTriangle(5, 5, 5, 40, 40, 5, 80, 80, 120, 120, 7);
        // A row may cost up to three box widths, stalls roughly double that
        cycleLimit = 200 + 4 * boxArea(emptyTri) + 50;
        for (int i = 0; i < randomTriCount + stallTriCount; i++)
        begin
            triList.push_back(randomTriangle());
            factor     = (i < randomTriCount) ? 1 : 3;
            cycleLimit = cycleLimit + factor * (4 * boxArea(triList[i]) + 50);
        end
        cycleLimit = cycleLimit + 1000;

        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // Idle outputs with no start pulse
        currentTest   = "idleAfterReset";
        errorsBefore  = errorCount;
        expectedCount = 0;
        receivedCount = 0;
        repeat (20)
        begin
            @(posedge clk);
            #2;
            checkFlag("idleAfterReset rasterizerRunning", 1'b0, rasterizerRunning);
            checkFlag("idleAfterReset fragValid", 1'b0, fragValid);
        end
        closeTest("idleAfterReset", errorsBefore);

        for (int i = 0; i < randomTriCount + stallTriCount; i++)
            renderTriangle($sformatf("%s%0d", (i < randomTriCount) ? "readyTri" : "stallTri", i),
                           triList[i], i >= randomTriCount);

        renderTriangle("emptyBox", emptyTri, 1'b0);
        checkCount("emptyBox fragments received", 0, receivedCount);

        $display("Tests run: %0d, tests failed: %0d, errors: %0d", testCount, failedTests,
                 errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
